//--- verilog.f
+incdir+verif
hw/cpu_pkg.sv
hw/result_bus_if.sv
hw/stage_reg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/writeback_stage.sv
hw/pipeline_top.sv
verif/pipeline_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f --top-module pipeline_tb \
		-Mdir obj_dir -o pipeline_sim
	./obj_dir/pipeline_sim 2>&1 | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- verif/test_table.svh
`ifndef TEST_TABLE_SVH
`define TEST_TABLE_SVH

// Columns: test programs as instruction words, then up to MAX_EXP checks per test
// Each check is (kind, register or data word index, expected value)

localparam int NUM_TESTS = 5;
localparam int MAX_PROG  = 10; // Short programs padded with nops
localparam int MAX_EXP   = 5;

localparam cpu_pkg::word_t HALT_WORD = {cpu_pkg::OP_HALT, 26'd0};

typedef enum logic [1:0] {CHK_NONE, CHK_REG, CHK_MEM} check_kind_t;

typedef struct packed {
    check_kind_t    kind;
    int             addr;  // Register number or data word index
    cpu_pkg::word_t value;
} check_t;

localparam check_t NO_CHECK = '{CHK_NONE, 0, 32'd0};

cpu_pkg::word_t prog_tbl [NUM_TESTS][MAX_PROG];
check_t         exp_tbl  [NUM_TESTS][MAX_EXP];
string          test_names [NUM_TESTS];

function automatic cpu_pkg::word_t rtype_word(input int rs, input int rt, input int rd,
                                              input logic [5:0] fn);
    return {cpu_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic cpu_pkg::word_t itype_word(input logic [5:0] op, input int rs, input int rt,
                                              input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm}; // rt is the destination or the store source
endfunction

// Expected values follow the ISA rules, test 5 gets random immediates
task automatic build_table();
    logic [15:0]    ia;
    logic [15:0]    ib;
    cpu_pkg::word_t sa;
    cpu_pkg::word_t sb;
    ia = 16'($urandom);
    ib = 16'($urandom);
    sa = {{16{ia[15]}}, ia}; // addi sign-extends
    sb = {{16{ib[15]}}, ib};
    test_names = '{"alu ops", "forwarding", "load store", "r0 and halt", "random clock enable"};
    // r1 = 13, r2 = -6, two nops before first use
    prog_tbl[0] = '{itype_word(cpu_pkg::OP_ADDI, 0, 1, 16'd13),
        itype_word(cpu_pkg::OP_ADDI, 0, 2, 16'hFFFA), 32'd0, 32'd0,
        rtype_word(1, 2, 3, cpu_pkg::FN_ADD), rtype_word(1, 2, 4, cpu_pkg::FN_SUB),
        rtype_word(1, 2, 5, cpu_pkg::FN_AND), rtype_word(1, 2, 6, cpu_pkg::FN_OR),
        rtype_word(2, 1, 7, cpu_pkg::FN_SLT), HALT_WORD};
    exp_tbl[0] = '{'{CHK_REG, 3, 32'd7}, '{CHK_REG, 4, 32'd19}, '{CHK_REG, 5, 32'd8},
        '{CHK_REG, 6, 32'hFFFF_FFFF}, '{CHK_REG, 7, 32'd1}};
    // Back-to-back chain, every operand comes off the result bus
    prog_tbl[1] = '{itype_word(cpu_pkg::OP_ADDI, 0, 1, 16'd5),
        rtype_word(1, 1, 2, cpu_pkg::FN_ADD), rtype_word(2, 1, 3, cpu_pkg::FN_ADD),
        rtype_word(3, 2, 4, cpu_pkg::FN_SUB), HALT_WORD, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0};
    exp_tbl[1] = '{'{CHK_REG, 1, 32'd5}, '{CHK_REG, 2, 32'd10}, '{CHK_REG, 3, 32'd15},
        '{CHK_REG, 4, 32'd5}, NO_CHECK};
    // Stores to words 0 and 2, loads back, one spacer before the use
    prog_tbl[2] = '{itype_word(cpu_pkg::OP_ADDI, 0, 1, 16'h0055),
        itype_word(cpu_pkg::OP_ADDI, 0, 2, 16'hFFFF), itype_word(cpu_pkg::OP_SW, 0, 1, 16'd0),
        itype_word(cpu_pkg::OP_SW, 0, 2, 16'd8), itype_word(cpu_pkg::OP_LW, 0, 3, 16'd0),
        itype_word(cpu_pkg::OP_LW, 0, 4, 16'd8), 32'd0, rtype_word(3, 4, 5, cpu_pkg::FN_ADD),
        HALT_WORD, 32'd0};
    exp_tbl[2] = '{'{CHK_REG, 3, 32'h55}, '{CHK_REG, 4, 32'hFFFF_FFFF}, '{CHK_REG, 5, 32'h54},
        '{CHK_MEM, 0, 32'h55}, '{CHK_MEM, 2, 32'hFFFF_FFFF}};
    // Writes aimed at r0, then two addi after the halt that must not land
    prog_tbl[3] = '{itype_word(cpu_pkg::OP_ADDI, 0, 0, 16'd77),
        itype_word(cpu_pkg::OP_ADDI, 0, 1, 16'd3), rtype_word(1, 1, 0, cpu_pkg::FN_ADD),
        rtype_word(0, 1, 2, cpu_pkg::FN_ADD), HALT_WORD, itype_word(cpu_pkg::OP_ADDI, 0, 3, 16'd1),
        itype_word(cpu_pkg::OP_ADDI, 0, 2, 16'd100), 32'd0, 32'd0, 32'd0};
    exp_tbl[3] = '{'{CHK_REG, 0, 32'd0}, '{CHK_REG, 1, 32'd3}, '{CHK_REG, 2, 32'd3},
        '{CHK_REG, 3, 32'd0}, NO_CHECK};
    prog_tbl[4] = '{itype_word(cpu_pkg::OP_ADDI, 0, 1, ia), itype_word(cpu_pkg::OP_ADDI, 0, 2, ib),
        rtype_word(1, 2, 3, cpu_pkg::FN_ADD), rtype_word(1, 2, 4, cpu_pkg::FN_SUB),
        rtype_word(3, 4, 5, cpu_pkg::FN_ADD), rtype_word(5, 1, 6, cpu_pkg::FN_SUB),
        HALT_WORD, 32'd0, 32'd0, 32'd0};
    exp_tbl[4] = '{'{CHK_REG, 3, sa + sb}, '{CHK_REG, 4, sa - sb},
        '{CHK_REG, 5, (sa + sb) + (sa - sb)}, '{CHK_REG, 6, (sa + sb) + (sa - sb) - sa}, NO_CHECK};
endtask

`endif

//--- verif/pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_tb;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    logic               i_clk;
    logic               i_clk_en;
    logic               i_reset;
    cpu_pkg::word_t     i_du_data;
    cpu_pkg::word_t     i_du_inst_addr_wr;
    logic [7:0]         i_du_mem_addr;
    cpu_pkg::reg_addr_t i_du_reg_addr;
    logic               i_du_write_en;
    logic               o_halt;
    cpu_pkg::word_t     o_du_regs_mem_data;
    cpu_pkg::word_t     o_du_mem_data;

    int errors       = 0;
    int failed_tests = 0;
    int cycle_count  = 0;

    `include "test_table.svh"

    // Per test: full imem load under reset, run to halt, one cycle per check
    localparam int CYCLE_LIMIT = NUM_TESTS * (IMEM_WORDS + 8 + 20 + MAX_EXP) + 8;

    pipeline_top #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) dut (
        .i_clk(i_clk), .i_clk_en(i_clk_en), .i_reset(i_reset), .i_du_data(i_du_data),
        .i_du_inst_addr_wr(i_du_inst_addr_wr), .i_du_mem_addr(i_du_mem_addr),
        .i_du_reg_addr(i_du_reg_addr), .i_du_write_en(i_du_write_en), .o_halt(o_halt),
        .o_du_regs_mem_data(o_du_regs_mem_data), .o_du_mem_data(o_du_mem_data)
    );

    always #5 i_clk = ~i_clk; // 10 ns period

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, the pipeline never reached halt", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input cpu_pkg::word_t exp,
                              input cpu_pkg::word_t got);
        assert (got === exp) else begin
            $display("[ERROR] t=%0t ns %s expected %08h got %08h", $time, name, exp, got);
            errors++;
        end
    endtask

    // Program first, zeros behind it, all while reset is held
    task automatic load_program(input int t);
        @(posedge i_clk);
        i_reset  <= 1'b1;
        i_clk_en <= 1'b1;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            i_du_write_en     <= 1'b1;
            i_du_inst_addr_wr <= cpu_pkg::word_t'(i);
            i_du_data         <= (i < MAX_PROG) ? prog_tbl[t][i] : 32'd0;
            @(posedge i_clk);
        end
        i_du_write_en <= 1'b0;
        i_reset       <= 1'b0; // Fetch starts at address 0
    endtask

    task automatic run_to_halt(input bit toggle_en);
        @(negedge i_clk);
        while (!o_halt) begin
            @(posedge i_clk);
            if (toggle_en) begin
                i_clk_en <= ($urandom_range(3, 0) != 0); // Low about one cycle in four
            end
            @(negedge i_clk);
        end
        @(posedge i_clk);
        i_clk_en <= 1'b1;
    endtask

    // Debug reads are combinational, sampled half a cycle after the address moves
    task automatic check_results(input int t);
        check_t e;
        for (int i = 0; i < MAX_EXP; i++) begin
            e = exp_tbl[t][i];
            if (e.kind != CHK_NONE) begin
                @(posedge i_clk);
                i_du_reg_addr <= 5'(e.addr);
                i_du_mem_addr <= 8'(e.addr);
                @(negedge i_clk);
                if (e.kind == CHK_REG) begin
                    check_word($sformatf("o_du_regs_mem_data (r%0d)", e.addr), e.value,
                               o_du_regs_mem_data);
                end else begin
                    check_word($sformatf("o_du_mem_data (word %0d)", e.addr), e.value,
                               o_du_mem_data);
                end
            end
        end
    endtask

    initial begin
        int errs_before;
        i_clk             = 1'b0;
        i_clk_en          = 1'b1;
        i_reset           = 1'b1;
        i_du_data         = '0;
        i_du_inst_addr_wr = '0;
        i_du_mem_addr     = '0;
        i_du_reg_addr     = '0;
        i_du_write_en     = 1'b0;
        void'($urandom(60));
        build_table();
        repeat (8) @(posedge i_clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = errors;
            load_program(t);
            run_to_halt(t == 4); // Only the last test stalls the clock enable
            check_results(t);
            if (errors == errs_before) begin
                $display("test %0d %s: ok", t + 1, test_names[t]);
            end else begin
                failed_tests++;
                $display("test %0d %s: %0d mismatches", t + 1, test_names[t],
                         errors - errs_before);
            end
        end
        $display("%0d of %0d tests ok, %0d failed", NUM_TESTS - failed_tests, NUM_TESTS,
                 failed_tests);
        if (failed_tests == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/pipeline_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic               i_clk,
    input  logic               i_clk_en,          // Global clock enable
    input  logic               i_reset,
    input  cpu_pkg::word_t     i_du_data,         // Program word to load
    input  cpu_pkg::word_t     i_du_inst_addr_wr, // Instruction word index
    input  logic [7:0]         i_du_mem_addr,
    input  cpu_pkg::reg_addr_t i_du_reg_addr,
    input  logic               i_du_write_en,     // Only while i_reset is high
    output logic               o_halt,
    output cpu_pkg::word_t     o_du_regs_mem_data, // Register at i_du_reg_addr
    output cpu_pkg::word_t     o_du_mem_data       // Data word at i_du_mem_addr
);

    logic             advance;
    cpu_pkg::if_id_t  if_d;  // Fetch output
    cpu_pkg::if_id_t  if_q;  // IF/ID
    cpu_pkg::id_ex_t  id_d;
    cpu_pkg::id_ex_t  id_q;  // ID/EX
    cpu_pkg::ex_mem_t ex_d;
    cpu_pkg::ex_mem_t ex_q;  // EX/MEM
    cpu_pkg::mem_wb_t mem_d;
    cpu_pkg::mem_wb_t mem_q; // MEM/WB

    result_bus_if rbus ();

    fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .i_clk(i_clk), .i_reset(i_reset), .i_advance(advance),
        .i_du_write_en(i_du_write_en), .i_du_inst_addr_wr(i_du_inst_addr_wr),
        .i_du_data(i_du_data), .o_if(if_d)
    );

    stage_reg #(.T(cpu_pkg::if_id_t)) u_if_id (
        .i_clk(i_clk), .i_reset(i_reset), .i_advance(advance), .i_d(if_d), .o_q(if_q)
    );

    decode_stage u_decode (
        .i_clk(i_clk), .i_reset(i_reset), .i_if(if_q), .rbus(rbus.sink),
        .i_du_reg_addr(i_du_reg_addr), .o_du_reg_data(o_du_regs_mem_data), .o_id(id_d)
    );

    stage_reg #(.T(cpu_pkg::id_ex_t)) u_id_ex (
        .i_clk(i_clk), .i_reset(i_reset), .i_advance(advance), .i_d(id_d), .o_q(id_q)
    );

    execute_stage u_execute (
        .i_id(id_q), .rbus(rbus.sink), .o_ex(ex_d)
    );

    stage_reg #(.T(cpu_pkg::ex_mem_t)) u_ex_mem (
        .i_clk(i_clk), .i_reset(i_reset), .i_advance(advance), .i_d(ex_d), .o_q(ex_q)
    );

    memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
        .i_clk(i_clk), .i_advance(advance), .i_ex(ex_q),
        .i_du_mem_addr(i_du_mem_addr), .o_du_mem_data(o_du_mem_data),
        .rbus(rbus.mem_src), .o_mem(mem_d)
    );

    stage_reg #(.T(cpu_pkg::mem_wb_t)) u_mem_wb (
        .i_clk(i_clk), .i_reset(i_reset), .i_advance(advance), .i_d(mem_d), .o_q(mem_q)
    );

    writeback_stage u_writeback (
        .i_clk(i_clk), .i_reset(i_reset), .i_clk_en(i_clk_en), .i_wb(mem_q),
        .rbus(rbus.wb_src), .o_advance(advance), .o_halt(o_halt)
    );

endmodule

`default_nettype wire

//--- hw/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_clk_en,
    input  cpu_pkg::mem_wb_t i_wb,
    result_bus_if.wb_src     rbus,
    output logic             o_advance, // Global step for every stage
    output logic             o_halt
);

    logic halted; // Sticky until reset

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            halted <= 1'b0;
        end else if (o_advance && i_wb.halt) begin
            halted <= 1'b1; // Halt leaving MEM/WB freezes everything
        end
    end

    assign o_advance = i_clk_en && !halted;
    assign o_halt    = halted;

    // Instructions behind the halt never reach the register file
    assign rbus.wb_reg_write = i_wb.reg_write && !halted;
    assign rbus.wb_rd        = i_wb.rd;
    assign rbus.wb_data      = i_wb.mem_to_reg ? i_wb.read_data : i_wb.alu_result;

endmodule

`default_nettype wire

//--- hw/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic             i_clk,
    input  logic             i_advance, // Stores commit only on a real step
    input  cpu_pkg::ex_mem_t i_ex,
    input  logic [7:0]       i_du_mem_addr, // Word index
    output cpu_pkg::word_t   o_du_mem_data,
    result_bus_if.mem_src    rbus,
    output cpu_pkg::mem_wb_t o_mem
);

    localparam int AW = $clog2(DMEM_WORDS);

    cpu_pkg::word_t dmem [DMEM_WORDS]; // Data memory, word addressed
    cpu_pkg::word_t word_idx;
    cpu_pkg::word_t du_idx;
    logic           in_range;

    assign word_idx = {2'b00, i_ex.alu_result[cpu_pkg::XLEN-1:2]};
    assign du_idx   = cpu_pkg::word_t'(i_du_mem_addr);
    assign in_range = (word_idx < DMEM_WORDS);

    always_ff @(posedge i_clk) begin
        if (i_ex.mem_write && i_advance && in_range) begin
            dmem[word_idx[AW-1:0]] <= i_ex.store_data;
        end
    end

    assign o_du_mem_data = (du_idx < DMEM_WORDS) ? dmem[du_idx[AW-1:0]] : '0;

    assign o_mem.read_data  = in_range ? dmem[word_idx[AW-1:0]] : '0; // Async load
    assign o_mem.alu_result = i_ex.alu_result;
    assign o_mem.rd         = i_ex.rd;
    assign o_mem.mem_to_reg = i_ex.mem_read;
    assign o_mem.reg_write  = i_ex.reg_write;
    assign o_mem.halt       = i_ex.halt;

    // EX/MEM forwarding source
    assign rbus.mem_reg_write = i_ex.reg_write;
    assign rbus.mem_rd        = i_ex.rd;
    assign rbus.mem_result    = i_ex.alu_result;

    // Only whole aligned words are supported
    a_word_aligned : assert property (@(posedge i_clk)
        (i_advance && (i_ex.mem_read || i_ex.mem_write)) |-> (i_ex.alu_result[1:0] == 2'b00))
        else $error("unaligned data memory access");

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  cpu_pkg::id_ex_t  i_id,
    result_bus_if.sink       rbus,
    output cpu_pkg::ex_mem_t o_ex
);

    cpu_pkg::word_t op_a;  // Forwarded rs
    cpu_pkg::word_t fwd_b; // Forwarded rt, also store data
    cpu_pkg::word_t op_b;  // After immediate select
    cpu_pkg::word_t alu_y;

    // EX/MEM wins over MEM/WB, r0 never forwarded
    function automatic cpu_pkg::word_t forward(
        input cpu_pkg::reg_addr_t src,
        input cpu_pkg::word_t     reg_val,
        input logic               mem_we,
        input cpu_pkg::reg_addr_t mem_rd,
        input cpu_pkg::word_t     mem_val,
        input logic               wb_we,
        input cpu_pkg::reg_addr_t wb_rd,
        input cpu_pkg::word_t     wb_val
    );
        if (src == '0) return reg_val;
        if (mem_we && (mem_rd == src)) return mem_val;
        if (wb_we && (wb_rd == src)) return wb_val;
        return reg_val;
    endfunction

    assign op_a  = forward(i_id.rs, i_id.rs_data, rbus.mem_reg_write, rbus.mem_rd,
                           rbus.mem_result, rbus.wb_reg_write, rbus.wb_rd, rbus.wb_data);
    assign fwd_b = forward(i_id.rt, i_id.rt_data, rbus.mem_reg_write, rbus.mem_rd,
                           rbus.mem_result, rbus.wb_reg_write, rbus.wb_rd, rbus.wb_data);
    assign op_b  = i_id.alu_src ? i_id.imm : fwd_b;

    always_comb begin
        case (i_id.alu_op)
            cpu_pkg::ALU_SUB: alu_y = op_a - op_b;
            cpu_pkg::ALU_AND: alu_y = op_a & op_b;
            cpu_pkg::ALU_OR:  alu_y = op_a | op_b;
            cpu_pkg::ALU_SLT: alu_y = cpu_pkg::word_t'($signed(op_a) < $signed(op_b));
            default:          alu_y = op_a + op_b; // add, addi, address calc
        endcase
    end

    assign o_ex.alu_result = alu_y;
    assign o_ex.store_data = fwd_b;
    assign o_ex.rd         = i_id.rd;
    assign o_ex.mem_read   = i_id.mem_read;
    assign o_ex.mem_write  = i_id.mem_write;
    assign o_ex.reg_write  = i_id.reg_write;
    assign o_ex.halt       = i_id.halt;

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic               i_clk,
    input  logic               i_reset,
    input  cpu_pkg::if_id_t    i_if,
    result_bus_if.sink         rbus,
    input  cpu_pkg::reg_addr_t i_du_reg_addr,
    output cpu_pkg::word_t     o_du_reg_data,
    output cpu_pkg::id_ex_t    o_id
);

    cpu_pkg::word_t     regs [32]; // Register file
    logic [5:0]         opcode;
    logic [5:0]         funct;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::word_t     rs_data;
    cpu_pkg::word_t     rt_data;

    assign opcode = i_if.instr[31:26];
    assign rs     = i_if.instr[25:21];
    assign rt     = i_if.instr[20:16];
    assign rd     = i_if.instr[15:11];
    assign funct  = i_if.instr[5:0];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0; // Clear the whole register file
            end
        end else if (rbus.wb_reg_write && (rbus.wb_rd != '0)) begin
            regs[rbus.wb_rd] <= rbus.wb_data; // r0 writes dropped here
        end
    end

    // Write-first bypass so a writeback in this cycle is seen by the read
    assign rs_data = (rs == '0) ? '0 :
                     (rbus.wb_reg_write && (rbus.wb_rd == rs)) ? rbus.wb_data : regs[rs];
    assign rt_data = (rt == '0) ? '0 :
                     (rbus.wb_reg_write && (rbus.wb_rd == rt)) ? rbus.wb_data : regs[rt];

    assign o_du_reg_data = (i_du_reg_addr == '0) ? '0 : regs[i_du_reg_addr];

    always_comb begin
        o_id         = '0; // Unknown opcode falls through as a bubble
        o_id.rs_data = rs_data;
        o_id.rt_data = rt_data;
        o_id.imm     = {{16{i_if.instr[15]}}, i_if.instr[15:0]};
        o_id.rs      = rs;
        o_id.rt      = rt;
        o_id.rd      = rt; // I-type destination
        case (opcode)
            cpu_pkg::OP_RTYPE: begin
                o_id.rd        = rd;
                o_id.reg_write = 1'b1; // The zero word decodes here as a harmless r0 write
                case (funct)
                    cpu_pkg::FN_SUB: o_id.alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND: o_id.alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:  o_id.alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_SLT: o_id.alu_op = cpu_pkg::ALU_SLT;
                    default:         o_id.alu_op = cpu_pkg::ALU_ADD; // FN_ADD and the rest
                endcase
            end
            cpu_pkg::OP_ADDI: begin
                o_id.alu_src   = 1'b1;
                o_id.reg_write = 1'b1;
            end
            cpu_pkg::OP_LW: begin
                o_id.alu_src   = 1'b1; // Address = rs + imm
                o_id.mem_read  = 1'b1;
                o_id.reg_write = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                o_id.alu_src   = 1'b1;
                o_id.mem_write = 1'b1;
            end
            cpu_pkg::OP_HALT: o_id.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter int IMEM_WORDS = 256
) (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_advance,
    input  logic             i_du_write_en,     // Program load strobe
    input  cpu_pkg::word_t   i_du_inst_addr_wr, // Word index, not byte address
    input  cpu_pkg::word_t   i_du_data,
    output cpu_pkg::if_id_t  o_if
);

    localparam int AW = $clog2(IMEM_WORDS);

    cpu_pkg::word_t imem [IMEM_WORDS]; // Instruction memory
    cpu_pkg::word_t pc;
    cpu_pkg::word_t fetch_idx;         // Word index of pc

    assign fetch_idx = {2'b00, pc[cpu_pkg::XLEN-1:2]};

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc <= '0; // Program starts at address 0
        end else if (i_advance) begin
            pc <= pc + 32'd4;
        end
    end

    // Debug load port
    always_ff @(posedge i_clk) begin
        if (i_du_write_en && (i_du_inst_addr_wr < IMEM_WORDS)) begin
            imem[i_du_inst_addr_wr[AW-1:0]] <= i_du_data;
        end
    end

    assign o_if.instr    = (fetch_idx < IMEM_WORDS) ? imem[fetch_idx[AW-1:0]] : '0; // Past end reads nop
    assign o_if.pc_plus4 = pc + 32'd4;

    // Loading only while the pipeline is held in reset
    a_load_in_reset : assert property (@(posedge i_clk) i_du_write_en |-> i_reset)
        else $error("instruction memory written while pipeline is running");

endmodule

`default_nettype wire

//--- hw/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

// One pipeline register, payload type chosen per instance
module stage_reg #(
    parameter type T = logic
) (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_advance, // Low while frozen or clock-enable is off
    input  T     i_d,
    output T     o_q
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_q <= '0; // All-zero payload is a bubble
        end else if (i_advance) begin
            o_q <= i_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/result_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface result_bus_if;

    logic               mem_reg_write; // EX/MEM result
    cpu_pkg::reg_addr_t mem_rd;
    cpu_pkg::word_t     mem_result;

    logic               wb_reg_write;  // MEM/WB result, also the regfile write port
    cpu_pkg::reg_addr_t wb_rd;
    cpu_pkg::word_t     wb_data;

    modport mem_src (output mem_reg_write, output mem_rd, output mem_result);

    modport wb_src (output wb_reg_write, output wb_rd, output wb_data);

    modport sink (
        input mem_reg_write, input mem_rd, input mem_result,
        input wb_reg_write, input wb_rd, input wb_data
    );

endinterface

`default_nettype wire

//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32; // Data and instruction width
    localparam int REG_ADDR_W = 5;  // 32 architectural registers

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;
    localparam logic [5:0] OP_HALT  = 6'h3F; // All ones

    // R-type function codes, instr[5:0]
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2A;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0, // Zero value so a bubble decodes as add
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4  // Signed compare
    } alu_op_t;

    typedef struct packed {
        word_t instr;    // Raw instruction word
        word_t pc_plus4; // Address of the next instruction
    } if_id_t;

    typedef struct packed {
        word_t     rs_data;   // Operand A from register file
        word_t     rt_data;   // Operand B from register file
        word_t     imm;       // Sign-extended immediate
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;        // Destination, rd or rt
        alu_op_t   alu_op;
        logic      alu_src;   // 1 selects imm for operand B
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      halt;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_result; // Also the memory byte address
        word_t     store_data; // Forwarded rt value
        reg_addr_t rd;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      halt;
    } ex_mem_t;

    typedef struct packed {
        word_t     read_data;  // Load result
        word_t     alu_result;
        reg_addr_t rd;
        logic      mem_to_reg; // 1 selects read_data at writeback
        logic      reg_write;
        logic      halt;
    } mem_wb_t;

endpackage

`default_nettype wire
